/* hw/stbuf_consts.svh */
`ifndef STBUF_CONSTS_SVH
`define STBUF_CONSTS_SVH

// ----------------------------------------------------------------------
// store buffer geometry
// ----------------------------------------------------------------------

// number of queue entries, any power of two
`define STBUF_DEPTH 4

// byte address width of stores and loads
`define STBUF_ADDR_BITS 16

// memory word
`define STBUF_DATA_BITS 32
`define STBUF_BYTES 4

`endif

/* hw/stbuf_pkg.sv */
`include "stbuf_consts.svh"

package stbuf_pkg;

   // store width, from the committed instruction
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } st_size_e;

   // committed store as it leaves the pipe, data right-justified
   typedef struct packed {
      logic                        valid;
      logic [`STBUF_ADDR_BITS-1:0] addr;
      st_size_e                    size;
      logic [`STBUF_DATA_BITS-1:0] data;
   } st_req_t;

   // store after lane alignment
   typedef struct packed {
      logic                                                valid;
      logic [`STBUF_ADDR_BITS-$clog2(`STBUF_BYTES)-1:0]    waddr;
      logic [`STBUF_BYTES-1:0]                             byteen;
      logic [`STBUF_DATA_BITS-1:0]                         data;   // lane-aligned
   } st_wr_t;

   typedef struct packed {
      logic [`STBUF_ADDR_BITS-$clog2(`STBUF_BYTES)-1:0]    waddr;
      logic [`STBUF_BYTES-1:0]                             byteen;
      logic [`STBUF_DATA_BITS-1:0]                         data;
   } stbuf_entry_t;

   // bytes found in the queue for a load
   typedef struct packed {
      logic [`STBUF_BYTES-1:0]     byteen;
      logic [`STBUF_DATA_BITS-1:0] data;
   } fwd_t;

endpackage

/* hw/stbuf_decode.sv */
`timescale 1ns/1ps
`include "stbuf_consts.svh"

module stbuf_decode (
   input  stbuf_pkg::st_req_t st_req,
   output stbuf_pkg::st_wr_t  wr
);

   import stbuf_pkg::*;

   localparam int OFFS_BITS = $clog2(`STBUF_BYTES);

   logic [`STBUF_BYTES-1:0]     base_be;    // enables before lane shift
   logic [2*`STBUF_BYTES-1:0]   be_ext;     // upper half catches word crossing
   logic [OFFS_BITS-1:0]        offs;
   logic [`STBUF_DATA_BITS-1:0] data_shift;
   logic                        crossing;

   assign offs = st_req.addr[OFFS_BITS-1:0];

   // size to byte pattern
   always_comb begin
      case (st_req.size)
         size_byte: base_be = `STBUF_BYTES'('b0001);
         size_half: base_be = `STBUF_BYTES'('b0011);
         size_word: base_be = `STBUF_BYTES'('b1111);
         default:   base_be = '0;
      endcase
   end

   // ----------------------------------------------------------------------
   // lane alignment
   // ----------------------------------------------------------------------
   assign be_ext     = {{`STBUF_BYTES{1'b0}}, base_be} << offs;
   assign data_shift = st_req.data << {offs, 3'b000};

   always_comb begin
      wr.valid  = st_req.valid;
      wr.waddr  = st_req.addr[`STBUF_ADDR_BITS-1:OFFS_BITS];
      wr.byteen = be_ext[`STBUF_BYTES-1:0];
      // zero the lanes the store does not own, keeps forwarding OR clean
      for (int b = 0; b < `STBUF_BYTES; b++) begin
         wr.data[8*b +: 8] = be_ext[b] ? data_shift[8*b +: 8] : 8'h00;
      end
   end

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   assign crossing = st_req.valid & (|be_ext[2*`STBUF_BYTES-1:`STBUF_BYTES]);

   // the pipe splits misaligned stores before they commit
   always_comb begin
      a_in_word: assert (crossing !== 1'b1)
         else $error("store at %h crosses a word boundary", st_req.addr);
   end

endmodule

/* hw/stbuf_execute.sv */
`timescale 1ns/1ps
`include "stbuf_consts.svh"

module stbuf_execute (
   input  logic                                             clk,
   input  logic                                             rst_n,
   input  stbuf_pkg::st_wr_t                                wr,
   input  logic                                             drain_commit,
   output stbuf_pkg::stbuf_entry_t [`STBUF_DEPTH-1:0]       entries,
   output logic [`STBUF_DEPTH-1:0]                          vld,
   output logic [$clog2(`STBUF_DEPTH)-1:0]                  rd_ptr,
   output logic                                             full,
   output logic                                             empty
);

   import stbuf_pkg::*;

   localparam int DEPTH = `STBUF_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [PTR_W-1:0]   wr_ptr;
   logic               pop;
   logic               coalesce;
   logic               alloc;
   logic [DEPTH-1:0]   clr;        // head entry leaving this cycle
   logic [DEPTH-1:0]   addr_hit;   // valid entry with same word address
   logic [DEPTH-1:0]   match;      // coalesce target
   logic [DEPTH-1:0]   wr_en;
   logic [CNT_W-1:0]   vld_cnt;

   stbuf_entry_t [DEPTH-1:0] nxt_entry;

   // ----------------------------------------------------------------------
   // pop and coalesce match
   // ----------------------------------------------------------------------
   assign pop = drain_commit & vld[rd_ptr];

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         clr[i]      = pop & (PTR_W'(i) == rd_ptr);
         addr_hit[i] = vld[i] & (entries[i].waddr == wr.waddr);
         // an entry on its way out cannot take new bytes
         match[i]    = wr.valid & addr_hit[i] & ~clr[i];
      end
   end

   assign coalesce = |match;
   assign alloc    = wr.valid & ~coalesce;

   // ----------------------------------------------------------------------
   // write enables and byte merge
   // ----------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         wr_en[i] = match[i] | (alloc & (PTR_W'(i) == wr_ptr));

         nxt_entry[i].waddr = wr.waddr;
         // merge keeps old enables, allocate starts fresh
         nxt_entry[i].byteen = match[i] ? (entries[i].byteen | wr.byteen) : wr.byteen;

         for (int b = 0; b < `STBUF_BYTES; b++) begin
            if (match[i] && !wr.byteen[b]) begin
               nxt_entry[i].data[8*b +: 8] = entries[i].data[8*b +: 8];  // old byte stays
            end else begin
               nxt_entry[i].data[8*b +: 8] = wr.data[8*b +: 8];
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // state
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld    <= '0;
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (wr_en[i]) begin
               vld[i] <= 1'b1;
            end else if (clr[i]) begin
               vld[i] <= 1'b0;
            end
         end
         if (alloc) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // payload, qualified by vld
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (wr_en[i]) begin
            entries[i] <= nxt_entry[i];
         end
      end
   end

   // ----------------------------------------------------------------------
   // occupancy
   // ----------------------------------------------------------------------
   always_comb begin
      vld_cnt = '0;
      for (int i = 0; i < DEPTH; i++) begin
         vld_cnt = vld_cnt + CNT_W'(vld[i]);
      end
   end

   assign full  = (vld_cnt == CNT_W'(DEPTH));
   assign empty = (vld_cnt == '0);

   // ----------------------------------------------------------------------
   // assertions
   // ----------------------------------------------------------------------

   // a store into a full queue must land on an existing word
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      (wr.valid && full) |-> coalesce)
      else $error("store into full buffer did not coalesce");

   // memory port pops only what it was shown
   a_commit_valid: assert property (@(posedge clk) disable iff (!rst_n)
      drain_commit |-> vld[rd_ptr])
      else $error("drain commit with empty head");

   // coalescing holds each word in one entry
   a_unique_word: assert property (@(posedge clk) disable iff (!rst_n)
      wr.valid |-> $onehot0(addr_hit))
      else $error("word address held in more than one entry");

endmodule

/* hw/stbuf_result.sv */
`timescale 1ns/1ps
`include "stbuf_consts.svh"

module stbuf_result (
   input  stbuf_pkg::stbuf_entry_t [`STBUF_DEPTH-1:0]          entries,
   input  logic [`STBUF_DEPTH-1:0]                             vld,
   input  logic [$clog2(`STBUF_DEPTH)-1:0]                     rd_ptr,
   input  logic [`STBUF_ADDR_BITS-1:0]                         ld_addr,
   output stbuf_pkg::fwd_t                                     fwd,
   output logic                                                drain_valid,
   output logic [`STBUF_ADDR_BITS-$clog2(`STBUF_BYTES)-1:0]    drain_addr,
   output logic [`STBUF_BYTES-1:0]                             drain_byteen,
   output logic [`STBUF_DATA_BITS-1:0]                         drain_data
);

   import stbuf_pkg::*;

   localparam int DEPTH     = `STBUF_DEPTH;
   localparam int OFFS_BITS = $clog2(`STBUF_BYTES);

   logic [`STBUF_ADDR_BITS-OFFS_BITS-1:0] ld_waddr;
   logic [DEPTH-1:0]                      ld_hit;
   stbuf_entry_t                          head;

   // ----------------------------------------------------------------------
   // load forwarding
   // ----------------------------------------------------------------------
   assign ld_waddr = ld_addr[`STBUF_ADDR_BITS-1:OFFS_BITS];

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         ld_hit[i] = vld[i] & (entries[i].waddr == ld_waddr);
      end
   end

   // at most one hit per word, so a plain OR is enough
   always_comb begin
      fwd = '0;
      for (int i = 0; i < DEPTH; i++) begin
         fwd.byteen = fwd.byteen | ({`STBUF_BYTES{ld_hit[i]}} & entries[i].byteen);
         fwd.data   = fwd.data | ({`STBUF_DATA_BITS{ld_hit[i]}} & entries[i].data);
      end
   end

   // ----------------------------------------------------------------------
   // drain
   // ----------------------------------------------------------------------
   assign head = entries[rd_ptr];

   assign drain_valid  = vld[rd_ptr];   // holds until the port commits
   assign drain_addr   = head.waddr;
   assign drain_byteen = head.byteen;
   assign drain_data   = head.data;

endmodule

/* hw/stbuf_top.sv */
`timescale 1ns/1ps
`include "stbuf_consts.svh"

module stbuf_top (
   input  logic                                             clk,
   input  logic                                             rst_n,
   input  stbuf_pkg::st_req_t                               st_req,
   input  logic                                             drain_commit,
   input  logic [`STBUF_ADDR_BITS-1:0]                      ld_addr,
   output logic                                             drain_valid,
   output logic [`STBUF_ADDR_BITS-$clog2(`STBUF_BYTES)-1:0] drain_addr,
   output logic [`STBUF_BYTES-1:0]                          drain_byteen,
   output logic [`STBUF_DATA_BITS-1:0]                      drain_data,
   output stbuf_pkg::fwd_t                                  fwd,
   output logic                                             full,
   output logic                                             empty
);

   import stbuf_pkg::*;

   st_wr_t                                  wr;
   stbuf_entry_t [`STBUF_DEPTH-1:0]         entries;
   logic [`STBUF_DEPTH-1:0]                 vld;
   logic [$clog2(`STBUF_DEPTH)-1:0]         rd_ptr;

   // raw store to lane-aligned write
   stbuf_decode u_decode (
      .st_req (st_req),
      .wr     (wr)
   );

   // ----------------------------------------------------------------------
   // queue
   // ----------------------------------------------------------------------
   stbuf_execute u_execute (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr           (wr),
      .drain_commit (drain_commit),
      .entries      (entries),
      .vld          (vld),
      .rd_ptr       (rd_ptr),
      .full         (full),
      .empty        (empty)
   );

   // forwarding and drain view of the registered entries
   stbuf_result u_result (
      .entries      (entries),
      .vld          (vld),
      .rd_ptr       (rd_ptr),
      .ld_addr      (ld_addr),
      .fwd          (fwd),
      .drain_valid  (drain_valid),
      .drain_addr   (drain_addr),
      .drain_byteen (drain_byteen),
      .drain_data   (drain_data)
   );

endmodule

/* testbench/tb_stbuf.sv */
`timescale 1ns/1ps
`include "stbuf_consts.svh"

module tb_stbuf;

   import stbuf_pkg::*;

   localparam int WADDR_BITS = `STBUF_ADDR_BITS - $clog2(`STBUF_BYTES);

   // one table row, stimulus then expected outputs
   typedef struct packed {
      logic                        st_valid;
      logic [`STBUF_ADDR_BITS-1:0] addr;
      st_size_e                    size;
      logic [`STBUF_DATA_BITS-1:0] data;
      logic                        commit;
      logic [`STBUF_ADDR_BITS-1:0] ld_addr;
      logic                        exp_dv;
      logic [WADDR_BITS-1:0]       exp_daddr;
      logic [`STBUF_BYTES-1:0]     exp_dbe;
      logic [`STBUF_DATA_BITS-1:0] exp_ddata;
      logic [`STBUF_BYTES-1:0]     exp_fbe;
      logic [`STBUF_DATA_BITS-1:0] exp_fdata;
      logic                        exp_full;
      logic                        exp_empty;
   } row_t;

   logic                        clk = 1'b0;
   logic                        rst_n;
   st_req_t                     st_req;
   logic                        drain_commit;
   logic [`STBUF_ADDR_BITS-1:0] ld_addr;
   logic                        drain_valid;
   logic [WADDR_BITS-1:0]       drain_addr;
   logic [`STBUF_BYTES-1:0]     drain_byteen;
   logic [`STBUF_DATA_BITS-1:0] drain_data;
   fwd_t                        fwd;
   logic                        full;
   logic                        empty;

   row_t rows[$];
   int   errors    = 0;
   int   checks    = 0;
   int   cycle_cnt = 0;

   stbuf_top UUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .st_req       (st_req),
      .drain_commit (drain_commit),
      .ld_addr      (ld_addr),
      .drain_valid  (drain_valid),
      .drain_addr   (drain_addr),
      .drain_byteen (drain_byteen),
      .drain_data   (drain_data),
      .fwd          (fwd),
      .full         (full),
      .empty        (empty)
   );

   always #5 clk = ~clk;

   // run limit of table length plus margin
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > rows.size() + 20) begin
         $display("timeout: table not finished after %0d cycles", cycle_cnt);
         $display("Simulation failed");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // table helpers
   // ----------------------------------------------------------------------
   task automatic add_row(input logic st_valid, input logic [15:0] addr, input st_size_e size,
                          input logic [31:0] data, input logic commit, input logic [15:0] ld,
                          input logic dv, input logic [13:0] daddr, input logic [3:0] dbe,
                          input logic [31:0] ddata, input logic [3:0] fbe,
                          input logic [31:0] fdata, input logic f, input logic e);
      row_t r;
      r = '{st_valid, addr, size, data, commit, ld, dv, daddr, dbe, ddata, fbe, fdata, f, e};
      rows.push_back(r);
   endtask

   task automatic drive_row(input int idx);
      st_req.valid = rows[idx].st_valid;
      st_req.addr  = rows[idx].addr;
      st_req.size  = rows[idx].size;
      st_req.data  = rows[idx].data;
      drain_commit = rows[idx].commit;
      ld_addr      = rows[idx].ld_addr;
   endtask

   task automatic report_mismatch(input int idx, input string what,
                                  input logic [31:0] got, input logic [31:0] exp);
      $display("MISMATCH at %0t: row %0d %s is %h, expected %h", $time, idx, what, got, exp);
      errors++;
   endtask

   task automatic check_row(input int idx);
      row_t r;
      r = rows[idx];
      checks++;
      if (drain_valid !== r.exp_dv) begin
         report_mismatch(idx, "drain_valid", 32'(drain_valid), 32'(r.exp_dv));
      end
      if (r.exp_dv) begin   // drain fields only mean something with a valid head
         if (drain_addr !== r.exp_daddr) begin
            report_mismatch(idx, "drain_addr", 32'(drain_addr), 32'(r.exp_daddr));
         end
         if (drain_byteen !== r.exp_dbe) begin
            report_mismatch(idx, "drain_byteen", 32'(drain_byteen), 32'(r.exp_dbe));
         end
         if (drain_data !== r.exp_ddata) begin
            report_mismatch(idx, "drain_data", drain_data, r.exp_ddata);
         end
      end
      if (fwd.byteen !== r.exp_fbe) begin
         report_mismatch(idx, "fwd.byteen", 32'(fwd.byteen), 32'(r.exp_fbe));
      end
      if (fwd.data !== r.exp_fdata) begin
         report_mismatch(idx, "fwd.data", fwd.data, r.exp_fdata);
      end
      if (full !== r.exp_full) begin
         report_mismatch(idx, "full", 32'(full), 32'(r.exp_full));
      end
      if (empty !== r.exp_empty) begin
         report_mismatch(idx, "empty", 32'(empty), 32'(r.exp_empty));
      end
   endtask

   // ----------------------------------------------------------------------
   // stimulus table
   // ----------------------------------------------------------------------
   // each row expects the state left by the earlier rows
   initial begin
      // after reset
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0100,
              0, 14'h000, 4'b0000, 32'h0, 4'b0000, 32'h0, 0, 1);
      add_row(1, 16'h0102, size_byte, 32'h0000_00a5, 0, 16'h0100,
              0, 14'h000, 4'b0000, 32'h0, 4'b0000, 32'h0, 0, 1);
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0100,
              1, 14'h040, 4'b0100, 32'h00a5_0000, 4'b0100, 32'h00a5_0000, 0, 0);
      // half store into the same word merges
      add_row(1, 16'h0100, size_half, 32'h0000_1234, 0, 16'h0100,
              1, 14'h040, 4'b0100, 32'h00a5_0000, 4'b0100, 32'h00a5_0000, 0, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0100,
              1, 14'h040, 4'b0111, 32'h00a5_1234, 4'b0111, 32'h00a5_1234, 0, 0);
      add_row(1, 16'h0100, size_word, 32'hdead_beef, 0, 16'h0100,
              1, 14'h040, 4'b0111, 32'h00a5_1234, 4'b0111, 32'h00a5_1234, 0, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0104,
              1, 14'h040, 4'b1111, 32'hdead_beef, 4'b0000, 32'h0, 0, 0);
      // fill with three more words and no forwarding in the store's own cycle
      add_row(1, 16'h0200, size_word, 32'h1111_1111, 0, 16'h0200,
              1, 14'h040, 4'b1111, 32'hdead_beef, 4'b0000, 32'h0, 0, 0);
      add_row(1, 16'h0302, size_half, 32'h0000_2222, 0, 16'h0200,
              1, 14'h040, 4'b1111, 32'hdead_beef, 4'b1111, 32'h1111_1111, 0, 0);
      add_row(1, 16'h0401, size_byte, 32'h0000_0033, 0, 16'h0302,
              1, 14'h040, 4'b1111, 32'hdead_beef, 4'b1100, 32'h2222_0000, 0, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0400,
              1, 14'h040, 4'b1111, 32'hdead_beef, 4'b0010, 32'h0000_3300, 1, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0100,
              1, 14'h040, 4'b1111, 32'hdead_beef, 4'b1111, 32'hdead_beef, 1, 0);
      // pop the head
      add_row(0, 16'h0000, size_byte, 32'h0, 1, 16'h0100,
              1, 14'h040, 4'b1111, 32'hdead_beef, 4'b1111, 32'hdead_beef, 1, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0100,
              1, 14'h080, 4'b1111, 32'h1111_1111, 4'b0000, 32'h0, 0, 0);
      // store to the head word while it pops must allocate
      add_row(1, 16'h0201, size_byte, 32'h0000_0044, 1, 16'h0200,
              1, 14'h080, 4'b1111, 32'h1111_1111, 4'b1111, 32'h1111_1111, 0, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0200,
              1, 14'h0c0, 4'b1100, 32'h2222_0000, 4'b0010, 32'h0000_4400, 0, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 1, 16'h0200,
              1, 14'h0c0, 4'b1100, 32'h2222_0000, 4'b0010, 32'h0000_4400, 0, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 1, 16'h0302,
              1, 14'h100, 4'b0010, 32'h0000_3300, 4'b0000, 32'h0, 0, 0);
      add_row(0, 16'h0000, size_byte, 32'h0, 1, 16'h0400,
              1, 14'h080, 4'b0010, 32'h0000_4400, 4'b0000, 32'h0, 0, 0);
      // drained out
      add_row(0, 16'h0000, size_byte, 32'h0, 0, 16'h0200,
              0, 14'h000, 4'b0000, 32'h0, 4'b0000, 32'h0, 0, 1);
   end

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      rst_n        = 1'b0;
      st_req       = '0;
      drain_commit = 1'b0;
      ld_addr      = '0;

      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < rows.size(); i++) begin
         drive_row(i);
         #8;               // just before the next edge
         check_row(i);
         @(posedge clk);
         #1;
      end

      st_req       = '0;
      drain_commit = 1'b0;

      $display("rows checked: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+hw
hw/stbuf_pkg.sv
hw/stbuf_decode.sv
hw/stbuf_execute.sv
hw/stbuf_result.sv
hw/stbuf_top.sv
testbench/tb_stbuf.sv

/* Makefile */
# Verilator build and run of the store buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_stbuf
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation passed" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
